// File: logic/stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream field package
// Default AXI4-Stream field sizes and the values that
// disabled fields take on the output side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package stream_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default field sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int default_tdata_bytes = 1;   // Bytes in tdata
    localparam int default_tdest_width = 1;   // Bits in tdest
    localparam int default_tuser_width = 1;   // Bits in tuser
    localparam int default_tid_width = 1;     // Bits in tid

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Disabled field values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A missing keep or strobe means every byte is valid data,
    // so each lane bit reads as this value
    localparam logic tkeep_disabled_value = 1'b1;
    // Without tlast every beat closes its own packet
    localparam logic tlast_disabled_value = 1'b1;

endpackage

`default_nettype wire

// File: logic/queue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue package
// Memory styles and the pointer width helper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package queue_pkg;

    // Memory style that the storage array is built from
    typedef enum logic [1:0] {
        target_generic,      // Let synthesis pick
        target_block,        // Block RAM
        target_distributed   // LUT based RAM
    } target_t;

    // Bits needed to address a given number of entries
    function automatic int addr_width(input int entries);
        return (entries > 2) ? $clog2(entries) : 1;   // Never less than one bit
    endfunction

endpackage

`default_nettype wire

// File: logic/queue_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue memory
// Simple dual-port array, clocked write and registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module queue_memory #(
    parameter int width = 8,
    parameter int capacity = 16,
    parameter queue_pkg::target_t target = queue_pkg::target_generic,
    localparam int aw = queue_pkg::addr_width(capacity)
) (
    input  wire logic             aclk,
    input  wire logic             write_enable,
    input  wire logic [aw-1:0]    write_address,
    input  wire logic [width-1:0] write_word,
    input  wire logic             read_enable,
    input  wire logic [aw-1:0]    read_address,
    output logic      [width-1:0] read_word
);
    import queue_pkg::*;

    // Style hint for the array, picked from the target
    localparam string ram_style = (target == target_block) ? "block" :
        (target == target_distributed) ? "distributed" : "auto";

    (* ram_style = ram_style *)
    logic [width-1:0] mem [capacity];   // Storage array, contents undefined after reset

    always_ff @(posedge aclk) begin
        if (write_enable) begin
            mem[write_address] <= write_word;
        end
    end

    // Old contents come out when the same address is written this cycle
    always_ff @(posedge aclk) begin
        if (read_enable) begin
            read_word <= mem[read_address];   // Holds its value while not enabled
        end
    end

endmodule

`default_nettype wire

// File: logic/basic_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Basic queue
// FIFO control around the queue memory, with valid/ready
// on both sides and a registered output word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module basic_queue #(
    parameter int width = 8,
    parameter int capacity = 16,
    parameter queue_pkg::target_t target = queue_pkg::target_generic
) (
    input  wire logic             aclk,
    input  wire logic             rst,
    input  wire logic             rx_tvalid,
    output logic                  rx_tready,
    input  wire logic [width-1:0] rx_tdata,
    output logic                  tx_tvalid,
    input  wire logic             tx_tready,
    output logic      [width-1:0] tx_tdata
);
    import queue_pkg::*;

    localparam int aw = addr_width(capacity);
    localparam int cw = addr_width(capacity + 1);          // Count reaches capacity itself
    localparam logic [aw-1:0] last_address = aw'(capacity - 1);
    localparam logic [cw-1:0] full_count = cw'(capacity);

    logic [aw-1:0] write_pointer;   // Next slot to fill
    logic [aw-1:0] read_pointer;    // Oldest stored word
    logic [cw-1:0] count;           // Words held in memory, not counting the output word
    logic          write_enable;
    logic          read_enable;

    assign rx_tready = (count != full_count);              // Only a full memory stalls rx
    assign write_enable = rx_tvalid && rx_tready;

    // Read ahead whenever the output word is empty or leaving this cycle
    assign read_enable = (count != '0) && (!tx_tvalid || tx_tready);

    always_ff @(posedge aclk) begin
        if (rst) begin
            write_pointer <= '0;
            read_pointer <= '0;
            count <= '0;
            tx_tvalid <= 1'b0;
        end else begin
            if (write_enable) begin
                write_pointer <= (write_pointer == last_address) ? '0 : write_pointer + 1'b1;
            end
            if (read_enable) begin
                read_pointer <= (read_pointer == last_address) ? '0 : read_pointer + 1'b1;
            end
            count <= count + cw'(write_enable) - cw'(read_enable);   // Both at once keeps it
            // The output word is valid from the read until someone takes it
            if (read_enable) begin
                tx_tvalid <= 1'b1;
            end else if (tx_tready) begin
                tx_tvalid <= 1'b0;
            end
        end
    end

    // The memory's read register doubles as the output word
    queue_memory #(
        .width(width),
        .capacity(capacity),
        .target(target)
    ) memory (
        .aclk(aclk),
        .write_enable(write_enable),
        .write_address(write_pointer),
        .write_word(rx_tdata),
        .read_enable(read_enable),
        .read_address(read_pointer),
        .read_word(tx_tdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers meet with words stored only when the memory is full, so no write may land there
    assert property (@(posedge aclk) disable iff (rst)
        write_enable && count != '0 |-> write_pointer != read_pointer);

    // Count stays in range across every mix of reads and writes
    assert property (@(posedge aclk) disable iff (rst) count <= full_count);

endmodule

`default_nettype wire

// File: logic/stream_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream queue
// Packs the enabled AXI4-Stream fields into one word,
// queues it and unpacks it with defaults for the rest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module stream_queue #(
    parameter int tdata_bytes = stream_pkg::default_tdata_bytes,
    parameter int tdest_width = stream_pkg::default_tdest_width,
    parameter int tuser_width = stream_pkg::default_tuser_width,
    parameter int tid_width = stream_pkg::default_tid_width,
    parameter int use_tlast = 1,
    parameter int use_tkeep = 1,
    parameter int use_tstrb = 1,
    parameter int capacity = 256,
    parameter queue_pkg::target_t target = queue_pkg::target_generic,
    localparam int tdata_bits = (tdata_bytes > 0) ? tdata_bytes * 8 : 1,
    localparam int tkeep_bits = (tdata_bytes > 0) ? tdata_bytes : 1,
    localparam int tdest_bits = (tdest_width > 0) ? tdest_width : 1,
    localparam int tuser_bits = (tuser_width > 0) ? tuser_width : 1,
    localparam int tid_bits = (tid_width > 0) ? tid_width : 1
) (
    input  wire logic                  aclk,
    input  wire logic                  rst,
    input  wire logic                  rx_tvalid,
    output logic                       rx_tready,
    input  wire logic [tdata_bits-1:0] rx_tdata,
    input  wire logic [tkeep_bits-1:0] rx_tkeep,
    input  wire logic [tkeep_bits-1:0] rx_tstrb,
    input  wire logic                  rx_tlast,
    input  wire logic [tdest_bits-1:0] rx_tdest,
    input  wire logic [tuser_bits-1:0] rx_tuser,
    input  wire logic [tid_bits-1:0]   rx_tid,
    output logic                       tx_tvalid,
    input  wire logic                  tx_tready,
    output logic      [tdata_bits-1:0] tx_tdata,
    output logic      [tkeep_bits-1:0] tx_tkeep,
    output logic      [tkeep_bits-1:0] tx_tstrb,
    output logic                       tx_tlast,
    output logic      [tdest_bits-1:0] tx_tdest,
    output logic      [tuser_bits-1:0] tx_tuser,
    output logic      [tid_bits-1:0]   tx_tid
);
    import stream_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue word layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A zero width drops the field from the word
    localparam int tdata_width = tdata_bytes * 8;
    localparam int tstrb_width = (use_tstrb > 0) ? tdata_bytes : 0;
    localparam int tkeep_width = (use_tkeep > 0) ? tdata_bytes : 0;
    localparam int tlast_width = (use_tlast > 0) ? 1 : 0;
    localparam int width = tdata_width + tstrb_width + tkeep_width + tlast_width +
        tdest_width + tuser_width + tid_width;

    localparam int tdata_offset = 0;   // Data sits in the low bits
    localparam int tstrb_offset = tdata_offset + tdata_width;
    localparam int tkeep_offset = tstrb_offset + tstrb_width;
    localparam int tlast_offset = tkeep_offset + tkeep_width;
    localparam int tdest_offset = tlast_offset + tlast_width;
    localparam int tuser_offset = tdest_offset + tdest_width;
    localparam int tid_offset = tuser_offset + tuser_width;

    logic [width-1:0] rx_word;   // Packed beat going into the queue
    logic [width-1:0] tx_word;   // Packed beat coming out

    // Each field is either sliced in and out, or replaced by its default
    if (tdata_width > 0) begin : g_tdata_on
        assign rx_word[tdata_offset+:tdata_width] = rx_tdata;
        assign tx_tdata = tx_word[tdata_offset+:tdata_width];
    end else begin : g_tdata_off
        logic unused_tdata;
        assign unused_tdata = &{1'b0, rx_tdata, 1'b0};
        assign tx_tdata = '0;
    end

    if (tstrb_width > 0) begin : g_tstrb_on
        assign rx_word[tstrb_offset+:tstrb_width] = rx_tstrb;
        assign tx_tstrb = tx_word[tstrb_offset+:tstrb_width];
    end else begin : g_tstrb_off
        logic unused_tstrb;
        assign unused_tstrb = &{1'b0, rx_tstrb, 1'b0};
        assign tx_tstrb = {tkeep_bits{tkeep_disabled_value}};   // Same rule as keep
    end

    if (tkeep_width > 0) begin : g_tkeep_on
        assign rx_word[tkeep_offset+:tkeep_width] = rx_tkeep;
        assign tx_tkeep = tx_word[tkeep_offset+:tkeep_width];
    end else begin : g_tkeep_off
        logic unused_tkeep;
        assign unused_tkeep = &{1'b0, rx_tkeep, 1'b0};
        assign tx_tkeep = {tkeep_bits{tkeep_disabled_value}};
    end

    if (tlast_width > 0) begin : g_tlast_on
        assign rx_word[tlast_offset] = rx_tlast;
        assign tx_tlast = tx_word[tlast_offset];
    end else begin : g_tlast_off
        logic unused_tlast;
        assign unused_tlast = &{1'b0, rx_tlast, 1'b0};
        assign tx_tlast = tlast_disabled_value;
    end

    if (tdest_width > 0) begin : g_tdest_on
        assign rx_word[tdest_offset+:tdest_width] = rx_tdest;
        assign tx_tdest = tx_word[tdest_offset+:tdest_width];
    end else begin : g_tdest_off
        logic unused_tdest;
        assign unused_tdest = &{1'b0, rx_tdest, 1'b0};
        assign tx_tdest = '0;
    end

    if (tuser_width > 0) begin : g_tuser_on
        assign rx_word[tuser_offset+:tuser_width] = rx_tuser;
        assign tx_tuser = tx_word[tuser_offset+:tuser_width];
    end else begin : g_tuser_off
        logic unused_tuser;
        assign unused_tuser = &{1'b0, rx_tuser, 1'b0};
        assign tx_tuser = '0;
    end

    if (tid_width > 0) begin : g_tid_on
        assign rx_word[tid_offset+:tid_width] = rx_tid;
        assign tx_tid = tx_word[tid_offset+:tid_width];
    end else begin : g_tid_off
        logic unused_tid;
        assign unused_tid = &{1'b0, rx_tid, 1'b0};
        assign tx_tid = '0;
    end

    basic_queue #(
        .width(width),
        .capacity(capacity),
        .target(target)
    ) queue (
        .aclk(aclk),
        .rst(rst),
        .rx_tvalid(rx_tvalid),
        .rx_tready(rx_tready),
        .rx_tdata(rx_word),
        .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready),
        .tx_tdata(tx_word)
    );

endmodule

`default_nettype wire

// File: logic/stream_register_slice.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream register slice
// Two-entry skid buffer, registered ready, full throughput
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module stream_register_slice #(
    parameter int tdata_bytes = stream_pkg::default_tdata_bytes,
    parameter int tdest_width = stream_pkg::default_tdest_width,
    parameter int tuser_width = stream_pkg::default_tuser_width,
    parameter int tid_width = stream_pkg::default_tid_width,
    localparam int tdata_bits = (tdata_bytes > 0) ? tdata_bytes * 8 : 1,
    localparam int tkeep_bits = (tdata_bytes > 0) ? tdata_bytes : 1,
    localparam int tdest_bits = (tdest_width > 0) ? tdest_width : 1,
    localparam int tuser_bits = (tuser_width > 0) ? tuser_width : 1,
    localparam int tid_bits = (tid_width > 0) ? tid_width : 1
) (
    input  wire logic                  aclk,
    input  wire logic                  rst,
    input  wire logic                  rx_tvalid,
    output logic                       rx_tready,
    input  wire logic [tdata_bits-1:0] rx_tdata,
    input  wire logic [tkeep_bits-1:0] rx_tkeep,
    input  wire logic [tkeep_bits-1:0] rx_tstrb,
    input  wire logic                  rx_tlast,
    input  wire logic [tdest_bits-1:0] rx_tdest,
    input  wire logic [tuser_bits-1:0] rx_tuser,
    input  wire logic [tid_bits-1:0]   rx_tid,
    output logic                       tx_tvalid,
    input  wire logic                  tx_tready,
    output logic      [tdata_bits-1:0] tx_tdata,
    output logic      [tkeep_bits-1:0] tx_tkeep,
    output logic      [tkeep_bits-1:0] tx_tstrb,
    output logic                       tx_tlast,
    output logic      [tdest_bits-1:0] tx_tdest,
    output logic      [tuser_bits-1:0] tx_tuser,
    output logic      [tid_bits-1:0]   tx_tid
);
    localparam int width = tdata_bits + 2 * tkeep_bits + 1 + tdest_bits + tuser_bits + tid_bits;

    logic [width-1:0] rx_word;
    logic [width-1:0] main_word;    // Beat currently offered on tx
    logic [width-1:0] skid_word;    // Beat caught while tx was stalled
    logic             main_valid;
    logic             skid_valid;
    logic             main_load;    // Main register is free or emptying this edge

    assign rx_word = {rx_tid, rx_tuser, rx_tdest, rx_tlast, rx_tstrb, rx_tkeep, rx_tdata};
    assign {tx_tid, tx_tuser, tx_tdest, tx_tlast, tx_tstrb, tx_tkeep, tx_tdata} = main_word;
    assign tx_tvalid = main_valid;
    assign rx_tready = !skid_valid;   // Comes straight from a flop and drops only when both are full
    assign main_load = !main_valid || tx_tready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_load) begin
                main_valid <= skid_valid || rx_tvalid;
            end
            if (rx_tvalid && rx_tready && !main_load) begin
                skid_valid <= 1'b1;                       // Park the beat behind the stall
            end else if (main_load) begin
                skid_valid <= 1'b0;                       // Skid moves forward into main
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (main_load) begin
            main_word <= skid_valid ? skid_word : rx_word;   // Older beat goes first
        end
        if (rx_tvalid && rx_tready && !main_load) begin
            skid_word <= rx_word;
        end
    end

    // An offered beat must be held unchanged by its source until the slice takes it
    assert property (@(posedge aclk) disable iff (rst)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_word));

endmodule

`default_nettype wire

// File: logic/stream_fifo_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream FIFO top level
// Stream queue followed by a register slice on the output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module stream_fifo_top #(
    parameter int tdata_bytes = stream_pkg::default_tdata_bytes,
    parameter int tdest_width = stream_pkg::default_tdest_width,
    parameter int tuser_width = stream_pkg::default_tuser_width,
    parameter int tid_width = stream_pkg::default_tid_width,
    parameter int use_tlast = 1,
    parameter int use_tkeep = 1,
    parameter int use_tstrb = 1,
    parameter int capacity = 256,
    parameter queue_pkg::target_t target = queue_pkg::target_generic,
    localparam int tdata_bits = (tdata_bytes > 0) ? tdata_bytes * 8 : 1,
    localparam int tkeep_bits = (tdata_bytes > 0) ? tdata_bytes : 1,
    localparam int tdest_bits = (tdest_width > 0) ? tdest_width : 1,
    localparam int tuser_bits = (tuser_width > 0) ? tuser_width : 1,
    localparam int tid_bits = (tid_width > 0) ? tid_width : 1
) (
    input  wire logic                  aclk,
    input  wire logic                  rst,
    input  wire logic                  rx_tvalid,
    output logic                       rx_tready,
    input  wire logic [tdata_bits-1:0] rx_tdata,
    input  wire logic [tkeep_bits-1:0] rx_tkeep,
    input  wire logic [tkeep_bits-1:0] rx_tstrb,
    input  wire logic                  rx_tlast,
    input  wire logic [tdest_bits-1:0] rx_tdest,
    input  wire logic [tuser_bits-1:0] rx_tuser,
    input  wire logic [tid_bits-1:0]   rx_tid,
    output logic                       tx_tvalid,
    input  wire logic                  tx_tready,
    output logic      [tdata_bits-1:0] tx_tdata,
    output logic      [tkeep_bits-1:0] tx_tkeep,
    output logic      [tkeep_bits-1:0] tx_tstrb,
    output logic                       tx_tlast,
    output logic      [tdest_bits-1:0] tx_tdest,
    output logic      [tuser_bits-1:0] tx_tuser,
    output logic      [tid_bits-1:0]   tx_tid
);
    // Queue to slice link
    logic                  q_tvalid;
    logic                  q_tready;
    logic [tdata_bits-1:0] q_tdata;
    logic [tkeep_bits-1:0] q_tkeep;
    logic [tkeep_bits-1:0] q_tstrb;
    logic                  q_tlast;
    logic [tdest_bits-1:0] q_tdest;
    logic [tuser_bits-1:0] q_tuser;
    logic [tid_bits-1:0]   q_tid;

    stream_queue #(
        .tdata_bytes(tdata_bytes),
        .tdest_width(tdest_width),
        .tuser_width(tuser_width),
        .tid_width(tid_width),
        .use_tlast(use_tlast),
        .use_tkeep(use_tkeep),
        .use_tstrb(use_tstrb),
        .capacity(capacity),
        .target(target)
    ) queue (
        .aclk(aclk), .rst(rst),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep), .rx_tstrb(rx_tstrb), .rx_tlast(rx_tlast),
        .rx_tdest(rx_tdest), .rx_tuser(rx_tuser), .rx_tid(rx_tid),
        .tx_tvalid(q_tvalid), .tx_tready(q_tready), .tx_tdata(q_tdata),
        .tx_tkeep(q_tkeep), .tx_tstrb(q_tstrb), .tx_tlast(q_tlast),
        .tx_tdest(q_tdest), .tx_tuser(q_tuser), .tx_tid(q_tid)
    );

    // Disabled fields already carry their defaults, so the slice stores every field
    stream_register_slice #(
        .tdata_bytes(tdata_bytes),
        .tdest_width(tdest_width),
        .tuser_width(tuser_width),
        .tid_width(tid_width)
    ) slice (
        .aclk(aclk), .rst(rst),
        .rx_tvalid(q_tvalid), .rx_tready(q_tready), .rx_tdata(q_tdata),
        .rx_tkeep(q_tkeep), .rx_tstrb(q_tstrb), .rx_tlast(q_tlast),
        .rx_tdest(q_tdest), .rx_tuser(q_tuser), .rx_tid(q_tid),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep), .tx_tstrb(tx_tstrb), .tx_tlast(tx_tlast),
        .tx_tdest(tx_tdest), .tx_tuser(tx_tuser), .tx_tid(tx_tid)
    );

endmodule

`default_nettype wire

// File: verification/stream_fifo_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream FIFO testbench
// Directed tests on the stream FIFO top level, with a
// scoreboard that checks every beat leaving the DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module stream_fifo_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import stream_pkg::*;

    localparam int tdata_bytes = 2;
    localparam int tdest_width = 2;
    localparam int tuser_width = 3;
    localparam int tid_width = 2;
    localparam int use_tlast = 1;
    localparam int use_tkeep = 1;
    localparam int use_tstrb = 0;                        // Strobe is dropped and reads as ones
    localparam int capacity = 8;

    // Beat word is {tid, tuser, tdest, tlast, tstrb, tkeep, tdata}
    localparam int data_bits = tdata_bytes * 8;
    localparam int keep_lsb = data_bits;
    localparam int strb_lsb = keep_lsb + tdata_bytes;
    localparam int last_pos = strb_lsb + tdata_bytes;
    localparam int beat_bits = last_pos + 1 + tdest_width + tuser_width + tid_width;

    localparam int stream_beats = 40;
    localparam int fill_beats = capacity + 3;           // Memory, output word, two slice entries
    localparam int random_beats = 100;
    localparam int cycle_limit = (1 + stream_beats + fill_beats + 1 + random_beats) * 4 + 200;
    localparam int accept_limit = 50;                   // Cycles one beat may wait for rx_tready

    typedef logic [beat_bits-1:0] beat_t;

    logic                   aclk;
    logic                   rst;
    logic                   rx_tvalid;
    logic                   rx_tready;
    logic [data_bits-1:0]   rx_tdata;
    logic [tdata_bytes-1:0] rx_tkeep;
    logic [tdata_bytes-1:0] rx_tstrb;
    logic                   rx_tlast;
    logic [tdest_width-1:0] rx_tdest;
    logic [tuser_width-1:0] rx_tuser;
    logic [tid_width-1:0]   rx_tid;
    logic                   tx_tvalid;
    logic                   tx_tready;
    logic [data_bits-1:0]   tx_tdata;
    logic [tdata_bytes-1:0] tx_tkeep;
    logic [tdata_bytes-1:0] tx_tstrb;
    logic                   tx_tlast;
    logic [tdest_width-1:0] tx_tdest;
    logic [tuser_width-1:0] tx_tuser;
    logic [tid_width-1:0]   tx_tid;

    beat_t  expected_q[$];          // Beats accepted at rx, in the form they must leave
    string  test_name = "setup";
    integer seed = 53852;
    int     error_count = 0;
    int     beats_in = 0;
    int     beats_out = 0;
    int     cycle_count = 0;
    logic   sending_done;

    stream_fifo_top #(
        .tdata_bytes(tdata_bytes), .tdest_width(tdest_width),
        .tuser_width(tuser_width), .tid_width(tid_width),
        .use_tlast(use_tlast), .use_tkeep(use_tkeep), .use_tstrb(use_tstrb),
        .capacity(capacity)
    ) uut (
        .aclk(aclk), .rst(rst),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep), .rx_tstrb(rx_tstrb), .rx_tlast(rx_tlast),
        .rx_tdest(rx_tdest), .rx_tuser(rx_tuser), .rx_tid(rx_tid),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep), .tx_tstrb(tx_tstrb), .tx_tlast(tx_tlast),
        .tx_tdest(tx_tdest), .tx_tuser(tx_tuser), .tx_tid(tx_tid)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;                       // 20 ns period
    end

    // Hard stop so a stuck handshake cannot hang the run
    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles while running %s", cycle_count, test_name);
            $display("Beats in %0d, beats out %0d, errors %0d", beats_in, beats_out, error_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Disabled fields leave the DUT at their default values
    function automatic beat_t expected_beat(input beat_t sent);
        beat_t result;
        result = sent;
        if (use_tkeep == 0) result[keep_lsb+:tdata_bytes] = {tdata_bytes{tkeep_disabled_value}};
        if (use_tstrb == 0) result[strb_lsb+:tdata_bytes] = {tdata_bytes{tkeep_disabled_value}};
        if (use_tlast == 0) result[last_pos] = tlast_disabled_value;
        return result;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge aclk) begin : scoreboard_check
        beat_t actual;
        beat_t expected;
        if (!rst) begin
            // Output side goes first since a beat never leaves on the edge it arrives
            if (tx_tvalid && tx_tready) begin
                actual = {tx_tid, tx_tuser, tx_tdest, tx_tlast, tx_tstrb, tx_tkeep, tx_tdata};
                assert (expected_q.size() != 0) else begin
                    $display("Error in %s: beat %h came out with none expected", test_name, actual);
                    error_count++;
                end
                if (expected_q.size() != 0) begin
                    expected = expected_q.pop_front();
                    assert (actual == expected) else begin
                        $display("Fail %s: beat %0d expected %h actual %h",
                            test_name, beats_out, expected, actual);
                        error_count++;
                    end
                end
                beats_out++;
            end
            if (rx_tvalid && rx_tready) begin
                expected_q.push_back(expected_beat(
                    {rx_tid, rx_tuser, rx_tdest, rx_tlast, rx_tstrb, rx_tkeep, rx_tdata}));
                beats_in++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_beat(input beat_t beat);
        @(negedge aclk);
        {rx_tid, rx_tuser, rx_tdest, rx_tlast, rx_tstrb, rx_tkeep, rx_tdata} = beat;
        rx_tvalid = 1'b1;
    endtask

    // Returns just after the edge that takes the beat
    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!rx_tready && waited < accept_limit) begin
            @(negedge aclk);                            // rx_tready only moves on rising edges
            waited++;
        end
        assert (rx_tready) else begin
            $display("Error in %s: beat not accepted within %0d cycles", test_name, accept_limit);
            error_count++;
        end
        @(posedge aclk);
    endtask

    task automatic send_beat(input beat_t beat);
        drive_beat(beat);
        wait_accept();
    endtask

    task automatic idle_rx();
        @(negedge aclk);
        rx_tvalid = 1'b0;
    endtask

    task automatic make_random_beat(output beat_t beat);
        beat = beat_t'($random(seed));
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < limit) begin
            @(negedge aclk);
            waited++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Error in %s: %0d beats never left the DUT", test_name, expected_q.size());
            error_count++;
        end
        assert (!tx_tvalid) else begin
            $display("Error in %s: output still valid after the last beat", test_name);
            error_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        test_name = "reset_state";
        @(negedge aclk);
        assert (tx_tvalid == 1'b0) else begin
            $display("Fail %s: tx_tvalid expected 0 actual %b", test_name, tx_tvalid);
            error_count++;
        end
        assert (rx_tready == 1'b1) else begin
            $display("Fail %s: rx_tready expected 1 actual %b", test_name, rx_tready);
            error_count++;
        end
    endtask

    task automatic test_single_beat();
        beat_t beat;
        int    edges;
        test_name = "single_beat";
        tx_tready = 1'b1;
        beat = {2'b11, 3'b101, 2'b10, 1'b1, 2'b01, 2'b10, 16'hA5C3};   // Every field non-zero
        send_beat(beat);
        idle_rx();
        edges = 0;
        while (!tx_tvalid && edges < 10) begin
            @(posedge aclk);
            edges++;
            @(negedge aclk);
        end
        // Memory read on the next edge, slice load on the one after
        assert (edges == 2) else begin
            $display("Fail %s: latency expected 2 actual %0d", test_name, edges);
            error_count++;
        end
        assert (tx_tstrb == {tdata_bytes{tkeep_disabled_value}}) else begin
            $display("Fail %s: tx_tstrb expected %b actual %b",
                test_name, {tdata_bytes{tkeep_disabled_value}}, tx_tstrb);
            error_count++;
        end
        wait_drained(20);
    endtask

    task automatic test_stream_order();
        beat_t beat;
        test_name = "stream_order";
        tx_tready = 1'b1;
        for (int i = 0; i < stream_beats; i++) begin
            make_random_beat(beat);
            send_beat(beat);                            // Back to back with no idle cycles
        end
        idle_rx();
        wait_drained(100);
    endtask

    task automatic test_fill_limit();
        beat_t beat;
        int    start_count;
        test_name = "fill_limit";
        tx_tready = 1'b0;                               // Nothing leaves while filling
        start_count = beats_in;
        for (int i = 0; i < fill_beats; i++) begin
            make_random_beat(beat);
            send_beat(beat);
        end
        make_random_beat(beat);
        drive_beat(beat);                               // One beat too many
        repeat (10) begin
            assert (!rx_tready) else begin
                $display("Error in %s: rx_tready rose while the FIFO was full", test_name);
                error_count++;
            end
            @(negedge aclk);
        end
        assert (beats_in - start_count == fill_beats) else begin
            $display("Fail %s: accepted beats expected %0d actual %0d",
                test_name, fill_beats, beats_in - start_count);
            error_count++;
        end
        tx_tready = 1'b1;                               // Draining lets the waiting beat in last
        wait_accept();
        idle_rx();
        wait_drained(100);
    endtask

    task automatic test_random_backpressure();
        beat_t beats[random_beats];
        int    gaps[random_beats];
        test_name = "random_backpressure";
        sending_done = 1'b0;
        for (int i = 0; i < random_beats; i++) begin
            make_random_beat(beats[i]);
            gaps[i] = $random(seed) & 3;                // Idle cycles after each beat
        end
        fork
            begin
                for (int i = 0; i < random_beats; i++) begin
                    send_beat(beats[i]);
                    if (gaps[i] > 0) begin
                        idle_rx();
                        repeat (gaps[i] - 1) @(negedge aclk);
                    end
                end
                idle_rx();
                sending_done = 1'b1;
            end
            begin
                while (!sending_done || expected_q.size() != 0) begin
                    @(negedge aclk);
                    tx_tready = ($random(seed) & 3) != 0;   // Stall about one cycle in four
                end
            end
        join
        @(negedge aclk);
        tx_tready = 1'b1;
        wait_drained(100);
    endtask

    initial begin
        rst = 1'b1;
        rx_tvalid = 1'b0;
        {rx_tid, rx_tuser, rx_tdest, rx_tlast, rx_tstrb, rx_tkeep, rx_tdata} = '0;
        tx_tready = 1'b0;
        repeat (16) @(negedge aclk);
        rst = 1'b0;
        test_reset_state();
        test_single_beat();
        test_stream_order();
        test_fill_limit();
        test_random_backpressure();
        $display("Beats in %0d, beats out %0d, errors %0d", beats_in, beats_out, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/stream_pkg.sv
logic/queue_pkg.sv
logic/queue_memory.sv
logic/basic_queue.sv
logic/stream_queue.sv
logic/stream_register_slice.sv
logic/stream_fifo_top.sv
verification/stream_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the stream FIFO testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module stream_fifo_tb \
    -f project.f -o stream_fifo_sim > build.log 2>&1 \
    && ./obj_dir/stream_fifo_sim > sim.log 2>&1

grep -qx "STATUS: PASS" sim.log 2>/dev/null \
    && echo "Simulation passed, see sim.log" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
